/* verilog/hdmi_audio_consts.svh */
`ifndef HDMI_AUDIO_CONSTS_SVH
`define HDMI_AUDIO_CONSTS_SVH

// 640x480 raster at 25.2 MHz
`define H_ACTIVE        640
`define H_TOTAL         800
`define V_TOTAL         525

// data-island slots inside horizontal blanking
`define SLOT_SPACING    32
`define SLOT_COUNT      4

// one sample every 787 pixel clocks gives roughly 32 kHz
`define SAMPLE_DIVIDER  787
`define SAMPLE_STEP     16'd257

// sample buffer
`define FIFO_DEPTH      8
`define FIFO_COUNT_W    4

`endif

/* verilog/hdmi_audio_pkg.sv */
package hdmi_audio_pkg;

    // encodings follow the packet type codes of the transmitter core
    typedef enum logic [1:0]
    {
        pkt_null  = 2'd0,
        pkt_acr   = 2'd1, // audio clock regeneration
        pkt_audio = 2'd2
    } packet_kind_e;

    // one mono sawtooth word
    typedef struct packed
    {
        logic [15:0] level;
    } audio_sample_t;

    // a packet is reduced to its kind and a single sample word
    typedef struct packed
    {
        packet_kind_e  kind;
        audio_sample_t sample; // zero unless kind is pkt_audio
    } data_packet_t;

    typedef struct packed
    {
        logic [9:0] cx;
        logic [9:0] cy;
    } raster_pos_t;

endpackage

/* verilog/raster_timing.sv */
`timescale 1ns/10ps
`include "hdmi_audio_consts.svh"

module raster_timing
(
    input  logic                       clk_pixel,
    input  logic                       arst_n,
    output hdmi_audio_pkg::raster_pos_t pos,
    output logic                       frame_start,
    output logic                       slot
);

    logic [9:0] cx;
    logic [9:0] cy;

    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            cx <= '0;
            cy <= '0;
        end
        else if (cx == 10'(`H_TOTAL - 1))
        begin
            cx <= '0;
            if (cy == 10'(`V_TOTAL - 1))
                cy <= '0;
            else
                cy <= cy + 10'd1;
        end
        else
        begin
            cx <= cx + 10'd1;
        end
    end

    assign pos.cx = cx;
    assign pos.cy = cy;

    assign frame_start = (cx == 10'd0) && (cy == 10'd0);

    // slots sit at fixed offsets after the end of active video, on every line
    always_comb
    begin
        slot = 1'b0;
        for (int k = 0; k < `SLOT_COUNT; k++)
        begin
            if (cx == 10'(`H_ACTIVE + k * `SLOT_SPACING))
                slot = 1'b1;
        end
    end

endmodule

/* verilog/sawtooth_source.sv */
`timescale 1ns/10ps
`include "hdmi_audio_consts.svh"

module sawtooth_source
(
    input  logic                         clk_pixel,
    input  logic                         arst_n,
    output hdmi_audio_pkg::audio_sample_t sample,
    output logic                         sample_strobe
);

    localparam int DIV_W = $clog2(`SAMPLE_DIVIDER);

    logic [DIV_W-1:0] div_cnt;
    logic [15:0]      level;

    // divider wraps once per sample period
    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            div_cnt       <= '0;
            sample_strobe <= 1'b0;
        end
        else
        begin
            sample_strobe <= (div_cnt == DIV_W'(`SAMPLE_DIVIDER - 1)); // the first strobe lands a full period after reset
            if (div_cnt == DIV_W'(`SAMPLE_DIVIDER - 1))
                div_cnt <= '0;
            else
                div_cnt <= div_cnt + DIV_W'(1);
        end
    end

    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
            level <= '0;
        else if (sample_strobe)
            level <= level + `SAMPLE_STEP; // wraps modulo 2^16
    end

    assign sample.level = level;

endmodule

/* verilog/sample_fifo.sv */
`timescale 1ns/10ps
`include "hdmi_audio_consts.svh"

module sample_fifo
(
    input  logic                         clk_pixel,
    input  logic                         arst_n,
    input  logic                         push,
    input  hdmi_audio_pkg::audio_sample_t push_data,
    input  logic                         pop,
    output hdmi_audio_pkg::audio_sample_t head,
    output logic [`FIFO_COUNT_W-1:0]     count
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);

    hdmi_audio_pkg::audio_sample_t mem [`FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             full;
    logic             push_ok;

    assign full    = (count == `FIFO_COUNT_W'(`FIFO_DEPTH));
    assign push_ok = push && !full; // overflow just loses the sample

    always_ff @(posedge clk_pixel)
    begin
        if (push_ok)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push_ok)
                wr_ptr <= (wr_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);

            // the scheduler never pops an empty buffer
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);

            case ({push_ok, pop})
                2'b10:   count <= count + `FIFO_COUNT_W'(1);
                2'b01:   count <= count - `FIFO_COUNT_W'(1);
                default: count <= count; // simultaneous push and pop cancel
            endcase
        end
    end

    assign head = mem[rd_ptr];

endmodule

/* verilog/packet_scheduler.sv */
`timescale 1ns/10ps
`include "hdmi_audio_consts.svh"

module packet_scheduler
(
    input  logic                         clk_pixel,
    input  logic                         arst_n,
    input  logic                         frame_start,
    input  logic                         slot,
    input  logic [`FIFO_COUNT_W-1:0]     count,
    input  hdmi_audio_pkg::audio_sample_t head,
    output logic                         pop,
    output hdmi_audio_pkg::data_packet_t  packet,
    output logic                         packet_strobe
);

    hdmi_audio_pkg::packet_kind_e kind_sel;
    hdmi_audio_pkg::data_packet_t packet_d;
    logic                         acr_sent;

    // regeneration packet first in each frame, then audio while anything is buffered
    always_comb
    begin
        if (!acr_sent)
            kind_sel = hdmi_audio_pkg::pkt_acr;
        else if (count != '0)
            kind_sel = hdmi_audio_pkg::pkt_audio;
        else
            kind_sel = hdmi_audio_pkg::pkt_null;
    end

    assign pop = slot && (kind_sel == hdmi_audio_pkg::pkt_audio);

    always_comb
    begin
        packet_d.kind   = kind_sel;
        packet_d.sample = (kind_sel == hdmi_audio_pkg::pkt_audio) ? head : '0;
    end

    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
            acr_sent <= 1'b0;
        else if (frame_start)
            acr_sent <= 1'b0;
        else if (slot && kind_sel == hdmi_audio_pkg::pkt_acr)
            acr_sent <= 1'b1;
    end

    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            packet_strobe <= 1'b0;
            packet        <= '0;
        end
        else
        begin
            packet_strobe <= slot;
            if (slot)
                packet <= packet_d; // held until the next slot
        end
    end

endmodule

/* verilog/hdmi_audio_top.sv */
`timescale 1ns/10ps
`include "hdmi_audio_consts.svh"

module hdmi_audio_top
(
    input  logic                        clk_pixel,
    input  logic                        arst_n,
    output hdmi_audio_pkg::raster_pos_t  pos,
    output hdmi_audio_pkg::data_packet_t packet,
    output logic                        packet_strobe,
    output logic [`FIFO_COUNT_W-1:0]    buffered
);

    logic                          frame_start;
    logic                          slot;
    logic                          sample_strobe;
    logic                          pop;
    hdmi_audio_pkg::audio_sample_t sample;
    hdmi_audio_pkg::audio_sample_t head;

    raster_timing raster_timing_i (
        .clk_pixel   (clk_pixel),
        .arst_n      (arst_n),
        .pos         (pos),
        .frame_start (frame_start),
        .slot        (slot)
    );

    sawtooth_source sawtooth_source_i (
        .clk_pixel     (clk_pixel),
        .arst_n        (arst_n),
        .sample        (sample),
        .sample_strobe (sample_strobe)
    );

    sample_fifo sample_fifo_i (
        .clk_pixel (clk_pixel),
        .arst_n    (arst_n),
        .push      (sample_strobe),
        .push_data (sample),
        .pop       (pop),
        .head      (head),
        .count     (buffered)
    );

    packet_scheduler packet_scheduler_i (
        .clk_pixel     (clk_pixel),
        .arst_n        (arst_n),
        .frame_start   (frame_start),
        .slot          (slot),
        .count         (buffered),
        .head          (head),
        .pop           (pop),
        .packet        (packet),
        .packet_strobe (packet_strobe)
    );

endmodule

/* test/hdmi_audio_properties.sv */
`timescale 1ns/10ps
`include "hdmi_audio_consts.svh"

module hdmi_audio_properties
(
    input logic                         clk_pixel,
    input logic                         arst_n,
    input hdmi_audio_pkg::raster_pos_t  pos,
    input hdmi_audio_pkg::data_packet_t packet,
    input logic                         packet_strobe,
    input logic [`FIFO_COUNT_W-1:0]     buffered,
    input logic                         sample_strobe,
    input logic                         pop
);

    logic [15:0] expected_level; // next sawtooth value an audio packet has to carry
    logic        first_pkt;      // no packet seen yet since the last frame start
    logic        slot_pos_d;
    logic        slot_seen;
    logic        was_empty;      // buffer fill in the slot cycle
    int unsigned pushes;
    int unsigned pops;
    int unsigned stall_cycles;
    int unsigned error_count = 0;

    function automatic logic is_slot_pos(input logic [9:0] cx);
        int offset;
        offset = int'(cx) - `H_ACTIVE;
        return (offset >= 0) && (offset < `SLOT_COUNT * `SLOT_SPACING)
            && (offset % `SLOT_SPACING == 0);
    endfunction

    task automatic flag_failure(input string msg);
        error_count = error_count + 1;
        $error("ERR %0t: %s", $time, msg);
    endtask

    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            expected_level <= '0;
            first_pkt      <= 1'b1;
            slot_pos_d     <= 1'b0;
            slot_seen      <= 1'b0;
            was_empty      <= 1'b1;
            pushes         <= 0;
            pops           <= 0;
            stall_cycles   <= 0;
        end
        else
        begin
            slot_pos_d <= is_slot_pos(pos.cx);
            was_empty  <= (buffered == '0);
            if (is_slot_pos(pos.cx))
                slot_seen <= 1'b1;
            if (pos.cx == 10'd0 && pos.cy == 10'd0)
                first_pkt <= 1'b1;
            else if (packet_strobe)
                first_pkt <= 1'b0;
            if (packet_strobe && packet.kind == hdmi_audio_pkg::pkt_audio)
                expected_level <= expected_level + `SAMPLE_STEP; // wraps modulo 2^16
            if (sample_strobe)
                pushes <= pushes + 1;
            if (pop)
                pops <= pops + 1;

            // a buffered sample must find a slot within one line
            if (pop || buffered == '0)
                stall_cycles <= 0;
            else
                stall_cycles <= stall_cycles + 1;
        end
    end

    a_idle_after_reset: assert property (@(posedge clk_pixel) disable iff (!arst_n)
        !slot_seen |-> (!packet_strobe && buffered == '0))
        else flag_failure("packet or buffered sample before the first slot");

    a_strobe_at_slot: assert property (@(posedge clk_pixel) disable iff (!arst_n)
        packet_strobe |-> slot_pos_d)
        else flag_failure("packet_strobe not one cycle after a slot position");

    a_strobe_single: assert property (@(posedge clk_pixel) disable iff (!arst_n)
        packet_strobe |=> !packet_strobe)
        else flag_failure("packet_strobe high two cycles in a row");

    a_acr_first: assert property (@(posedge clk_pixel) disable iff (!arst_n)
        packet_strobe |-> ((packet.kind == hdmi_audio_pkg::pkt_acr) == first_pkt))
        else flag_failure("regeneration packet not exactly first in the frame");

    a_audio_sequence: assert property (@(posedge clk_pixel) disable iff (!arst_n)
        (packet_strobe && packet.kind == hdmi_audio_pkg::pkt_audio)
            |-> packet.sample.level == expected_level)
        else flag_failure("audio packet sample differs from the sawtooth sequence");

    a_sample_zero: assert property (@(posedge clk_pixel) disable iff (!arst_n)
        (packet_strobe && packet.kind != hdmi_audio_pkg::pkt_audio)
            |-> packet.sample.level == 16'd0)
        else flag_failure("sample word not zero in a null or regeneration packet");

    a_kind_vs_fill: assert property (@(posedge clk_pixel) disable iff (!arst_n)
        (packet_strobe && packet.kind != hdmi_audio_pkg::pkt_acr)
            |-> was_empty == (packet.kind == hdmi_audio_pkg::pkt_null))
        else flag_failure("null or audio packet does not match the buffer fill");

    a_fill_bounds: assert property (@(posedge clk_pixel) disable iff (!arst_n)
        buffered <= `FIFO_COUNT_W'(`FIFO_DEPTH) && pushes == pops + 32'(buffered))
        else flag_failure("buffer fill above depth or a sample was dropped");

    a_delivery_latency: assert property (@(posedge clk_pixel) disable iff (!arst_n)
        stall_cycles < `H_TOTAL)
        else flag_failure("buffered sample not delivered within one line");

endmodule

bind hdmi_audio_top hdmi_audio_properties props_i (
    .clk_pixel     (clk_pixel),
    .arst_n        (arst_n),
    .pos           (pos),
    .packet        (packet),
    .packet_strobe (packet_strobe),
    .buffered      (buffered),
    .sample_strobe (sample_strobe),
    .pop           (pop)
);

/* test/hdmi_audio_tb.sv */
`timescale 1ns/10ps
`include "hdmi_audio_consts.svh"

module hdmi_audio_tb;

    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
    localparam int RUN_LIMIT    = 3 * FRAME_CYCLES; // well past the two frames of the run

    logic                         clk_pixel;
    logic                         arst_n;
    hdmi_audio_pkg::raster_pos_t  pos;
    hdmi_audio_pkg::data_packet_t packet;
    logic                         packet_strobe;
    logic [`FIFO_COUNT_W-1:0]     buffered;

    hdmi_audio_top dut_i (
        .clk_pixel     (clk_pixel),
        .arst_n        (arst_n),
        .pos           (pos),
        .packet        (packet),
        .packet_strobe (packet_strobe),
        .buffered      (buffered)
    );

    initial
    begin
        clk_pixel = 1'b0;
        forever #4 clk_pixel = ~clk_pixel;
    end

    // waits until the raster reaches the first pixel of the given line
    task automatic wait_for_line_start(input logic [9:0] line, input string what);
        int cycles;
        cycles = 0;
        while (!(pos.cx == 10'd0 && pos.cy == line) && cycles < FRAME_CYCLES)
        begin
            @(negedge clk_pixel);
            cycles++;
        end
        if (!(pos.cx == 10'd0 && pos.cy == line))
        begin
            $display("Verification failed");
            $fatal(1, "timed out waiting for %s", what);
        end
    endtask

    // the first failed assertion in the checker ends the run
    initial
    begin : watch_errors
        int cycles;
        cycles = 0;
        while (dut_i.props_i.error_count == 0 && cycles < RUN_LIMIT)
        begin
            @(negedge clk_pixel);
            cycles++;
        end
        $display("Verification failed");
        if (dut_i.props_i.error_count != 0)
            $fatal(1, "an assertion in the bound checker failed");
        else
            $fatal(1, "the run did not finish within its cycle limit");
    end

    initial
    begin
        arst_n = 1'b0;
        repeat (16) @(posedge clk_pixel);
        #1 arst_n = 1'b1;

        // slightly more than two frames
        wait_for_line_start(10'd1, "line 1 of frame 1");
        wait_for_line_start(10'd0, "start of frame 2");
        wait_for_line_start(10'd1, "line 1 of frame 2");
        wait_for_line_start(10'd0, "start of frame 3");
        wait_for_line_start(10'd4, "line 4 of frame 3");

        @(negedge clk_pixel);
        if (dut_i.props_i.error_count == 0)
        begin
            $display("Verification passed");
            $finish;
        end
        else
        begin
            $display("Verification failed");
            $fatal(1, "an assertion in the bound checker failed");
        end
    end

endmodule

/* compile.f */
+incdir+verilog
verilog/hdmi_audio_pkg.sv
verilog/raster_timing.sv
verilog/sawtooth_source.sv
verilog/sample_fifo.sv
verilog/packet_scheduler.sv
verilog/hdmi_audio_top.sv
test/hdmi_audio_properties.sv
test/hdmi_audio_tb.sv

/* run_sim.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f compile.f --top-module hdmi_audio_tb \
    -o hdmi_audio_sim \
    && ./obj_dir/hdmi_audio_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Verification passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
